/* rv_pkg.sv */
// ------------------------------------------------
// rv32i core shared definitions
// widths, accepted opcodes and ALU operations
// ------------------------------------------------
package rv_pkg;

    // datapath and address widths
    localparam int XLEN    = 32;
    localparam int REG_AW  = 5;
    localparam int IMEM_AW = 8;

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [REG_AW-1:0]  reg_idx_t;
    typedef logic [IMEM_AW-1:0] pc_t;

    // opcodes the core accepts
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // a0, reported on ecall
    localparam reg_idx_t ECALL_ARG_REG = 5'd10;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

endpackage

/* rv_fetch.sv */
// ------------------------------------------------
// run control and program counter
// idle/exec/done machine, next pc selection
// ------------------------------------------------
`timescale 1ns/100ps

module rv_fetch import rv_pkg::*; (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_is_ecall,
    input  logic i_redirect,
    input  pc_t  i_redirect_pc,
    output pc_t  o_pc,
    output logic o_fetch_valid
);

    typedef enum logic [1:0] {ST_IDLE, ST_EXEC, ST_DONE} run_state_e;

    run_state_e state;
    run_state_e state_nxt;
    pc_t        pc_nxt;

    always_comb begin
        state_nxt = state;
        pc_nxt    = o_pc;
        case (state)
            ST_IDLE: begin
                if (i_start) state_nxt = ST_EXEC;
            end
            ST_EXEC: begin
                // a taken branch or jump wins over whatever was fetched
                if (i_redirect) pc_nxt = i_redirect_pc;
                else if (i_is_ecall) state_nxt = ST_DONE;
                else pc_nxt = o_pc + 1'b1;
            end
            default: begin
                // done, held until reset
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
            o_pc  <= '0;
        end else begin
            state <= state_nxt;
            o_pc  <= pc_nxt;
        end
    end

    // wrong-path word is dropped while a redirect is active
    assign o_fetch_valid = (state == ST_EXEC) && !i_redirect;

    a_pc_frozen_in_done: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state == ST_DONE) |=> $stable(o_pc));

endmodule

/* rv_decode.sv */
// ------------------------------------------------
// instruction decoder and decode pipeline register
// ------------------------------------------------
`timescale 1ns/100ps

module rv_decode import rv_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  word_t      i_inst,
    input  pc_t        i_pc,
    input  logic       i_fetch_valid,
    output logic       o_is_ecall,
    output logic       o_valid,
    output pc_t        o_pc,
    output reg_idx_t   o_rd,
    output reg_idx_t   o_rs1,
    output reg_idx_t   o_rs2,
    output word_t      o_imm,
    output alu_op_e    o_alu_op,
    output logic       o_use_imm,
    output logic       o_reg_write,
    output logic       o_branch,
    output logic [2:0] o_br_funct3,
    output logic       o_jump,
    output logic       o_ecall
);

    // register and immediate forms share the funct3 map
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    word_t      imm_i, imm_b, imm_u, imm_j;
    word_t      imm;
    alu_op_e    alu_op;
    logic       known, use_imm, reg_write, branch, jump;
    logic       valid_in;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign rd     = i_inst[11:7];

    // sign-extended immediates
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'd0};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                    i_inst[30:21], 1'b0};

    assign o_is_ecall = (i_inst == {25'd0, OPC_SYSTEM});

    always_comb begin
        known     = 1'b0;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        imm       = imm_i;
        alu_op    = ALU_ADD;
        rs1       = i_inst[19:15];
        case (opcode)
            OPC_OP: begin
                known     = 1'b1;
                reg_write = 1'b1;
                alu_op    = arith_op(funct3, i_inst[30]);
            end
            OPC_OP_IMM: begin
                known     = 1'b1;
                reg_write = 1'b1;
                use_imm   = 1'b1;
                // bit 30 only selects srai; addi has no subtract form
                alu_op    = arith_op(funct3, i_inst[30] && (funct3 == 3'b101));
            end
            OPC_LUI: begin
                known     = 1'b1;
                reg_write = 1'b1;
                use_imm   = 1'b1;
                imm       = imm_u;
                alu_op    = ALU_PASS_B;
            end
            OPC_BRANCH: begin
                known  = 1'b1;
                branch = 1'b1;
                imm    = imm_b;
            end
            OPC_JAL: begin
                known     = 1'b1;
                reg_write = 1'b1;
                jump      = 1'b1;
                imm       = imm_j;
            end
            OPC_SYSTEM: begin
                known = o_is_ecall;
                rs1   = ECALL_ARG_REG;
            end
            default: begin
                // unknown opcode, leaves a bubble
            end
        endcase
        // x0 is never written
        if (rd == '0) reg_write = 1'b0;
    end

    assign valid_in = i_fetch_valid && known;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid     <= 1'b0;
            o_reg_write <= 1'b0;
            o_branch    <= 1'b0;
            o_jump      <= 1'b0;
            o_ecall     <= 1'b0;
        end else begin
            o_valid     <= valid_in;
            o_reg_write <= valid_in && reg_write;
            o_branch    <= valid_in && branch;
            o_jump      <= valid_in && jump;
            o_ecall     <= valid_in && o_is_ecall;
        end
    end

    // payload fields
    always_ff @(posedge i_clk) begin
        o_pc        <= i_pc;
        o_rd        <= rd;
        o_rs1       <= rs1;
        o_rs2       <= i_inst[24:20];
        o_imm       <= imm;
        o_alu_op    <= alu_op;
        o_use_imm   <= use_imm;
        o_br_funct3 <= funct3;
    end

    a_one_flow_change: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0({o_branch, o_jump, o_ecall}));

endmodule

/* rv_regfile.sv */
// ------------------------------------------------
// 32 x 32 register file, 2 read / 1 write, x0 = 0
// ------------------------------------------------
`timescale 1ns/100ps

module rv_regfile import rv_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_we,
    input  reg_idx_t i_wr_idx,
    input  word_t    i_wr_data,
    input  reg_idx_t i_rd_idx1,
    input  reg_idx_t i_rd_idx2,
    output word_t    o_rd_data1,
    output word_t    o_rd_data2
);

    word_t regs [2**REG_AW];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**REG_AW; i++) regs[i] <= '0;
        end else if (i_we) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    assign o_rd_data1 = (i_rd_idx1 == '0) ? '0 : regs[i_rd_idx1];
    assign o_rd_data2 = (i_rd_idx2 == '0) ? '0 : regs[i_rd_idx2];

    // decoder drops x0 destinations before they reach write-back
    a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_we |-> (i_wr_idx != '0));

endmodule

/* rv_execute.sv */
// ------------------------------------------------
// execute step: forwarding, ALU, branch and jal
// ------------------------------------------------
`timescale 1ns/100ps

module rv_execute import rv_pkg::*; (
    input  logic       i_valid,
    input  pc_t        i_pc,
    input  reg_idx_t   i_rs1,
    input  reg_idx_t   i_rs2,
    input  reg_idx_t   i_rd,
    input  word_t      i_rs1_data,
    input  word_t      i_rs2_data,
    input  word_t      i_imm,
    input  alu_op_e    i_alu_op,
    input  logic       i_use_imm,
    input  logic       i_reg_write,
    input  logic       i_branch,
    input  logic [2:0] i_br_funct3,
    input  logic       i_jump,
    input  logic       i_ecall,
    input  logic       i_fwd_we,
    input  reg_idx_t   i_fwd_idx,
    input  word_t      i_fwd_data,
    output logic       o_redirect,
    output pc_t        o_redirect_pc,
    output logic       o_reg_write,
    output reg_idx_t   o_rd,
    output word_t      o_result,
    output logic       o_ecall
);

    logic  fwd1, fwd2;
    word_t rs1_val, rs2_val, op_b;
    word_t alu_res;
    word_t link;
    pc_t   link_pc;
    logic  taken;

    // ------------------------------------------------
    // operand forwarding from the result register
    // ------------------------------------------------
    assign fwd1 = i_fwd_we && (i_fwd_idx == i_rs1) && (i_rs1 != '0);
    assign fwd2 = i_fwd_we && (i_fwd_idx == i_rs2) && (i_rs2 != '0);

    assign rs1_val = fwd1 ? i_fwd_data : i_rs1_data;
    assign rs2_val = fwd2 ? i_fwd_data : i_rs2_data;
    assign op_b    = i_use_imm ? i_imm : rs2_val;

    // ------------------------------------------------
    // ALU
    // ------------------------------------------------
    always_comb begin
        case (i_alu_op)
            ALU_ADD:  alu_res = rs1_val + op_b;
            ALU_SUB:  alu_res = rs1_val - op_b;
            ALU_SLL:  alu_res = rs1_val << op_b[4:0];
            ALU_SLT:  alu_res = word_t'($signed(rs1_val) < $signed(op_b));
            ALU_SLTU: alu_res = word_t'(rs1_val < op_b);
            ALU_XOR:  alu_res = rs1_val ^ op_b;
            ALU_SRL:  alu_res = rs1_val >> op_b[4:0];
            ALU_SRA:  alu_res = word_t'($signed(rs1_val) >>> op_b[4:0]);
            ALU_OR:   alu_res = rs1_val | op_b;
            ALU_AND:  alu_res = rs1_val & op_b;
            default:  alu_res = op_b;
        endcase
    end

    // branch compare, funct3 2 and 3 are not branches
    always_comb begin
        case (i_br_funct3)
            3'b000:  taken = (rs1_val == rs2_val);
            3'b001:  taken = (rs1_val != rs2_val);
            3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));
            3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            3'b110:  taken = (rs1_val < rs2_val);
            3'b111:  taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;
        endcase
    end

    // jal link is the byte address of the next word
    assign link_pc = i_pc + 1'b1;
    assign link    = word_t'({link_pc, 2'b00});

    assign o_redirect    = i_valid && ((i_branch && taken) || i_jump);
    // byte offset over 4, wraps at the pc width
    assign o_redirect_pc = i_valid ? pc_t'(i_pc + i_imm[IMEM_AW+1:2]) : '0;
    assign o_reg_write   = i_valid && i_reg_write;
    assign o_rd          = i_valid ? i_rd : '0;
    assign o_ecall       = i_valid && i_ecall;

    always_comb begin
        if (!i_valid) o_result = '0;
        else if (i_ecall) o_result = rs1_val;
        else if (i_jump) o_result = link;
        else o_result = alu_res;
    end

endmodule

/* rv_result.sv */
// ------------------------------------------------
// result step: write-back register, sticky ecall
// ------------------------------------------------
`timescale 1ns/100ps

module rv_result import rv_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_reg_write,
    input  reg_idx_t i_rd,
    input  word_t    i_result,
    input  logic     i_ecall,
    output logic     o_wb_we,
    output reg_idx_t o_wb_idx,
    output word_t    o_wb_data,
    output logic     o_ecall_ready,
    output word_t    o_ecall_data
);

    logic ecall_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_we       <= 1'b0;
            ecall_q       <= 1'b0;
            o_ecall_ready <= 1'b0;
            o_ecall_data  <= '0;
        end else begin
            o_wb_we <= i_reg_write;
            ecall_q <= i_ecall;
            // lands at the end of the result cycle, like a register write
            if (ecall_q && !o_ecall_ready) begin
                o_ecall_ready <= 1'b1;
                o_ecall_data  <= o_wb_data;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_idx  <= i_rd;
        o_wb_data <= i_result;
    end

    a_ecall_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_ecall_ready |=> (o_ecall_ready && $stable(o_ecall_data)));

endmodule

/* rv_core.sv */
// ------------------------------------------------
// rv32i core top, fetch/decode, execute, result
// ------------------------------------------------
`timescale 1ns/100ps

module rv_core import rv_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_start,
    output pc_t   o_imem_addr,
    input  word_t i_imem_data,
    output logic  o_ecall_ready,
    output word_t o_ecall_data
);

    // fetch side
    logic       fetch_valid;
    logic       is_ecall;
    logic       redirect;
    pc_t        redirect_pc;

    // decode register
    logic       dec_valid;
    pc_t        dec_pc;
    reg_idx_t   dec_rd, dec_rs1, dec_rs2;
    word_t      dec_imm;
    alu_op_e    dec_alu_op;
    logic       dec_use_imm, dec_reg_write, dec_branch, dec_jump, dec_ecall;
    logic [2:0] dec_br_funct3;

    word_t      rf_data1, rf_data2;

    // execute to result
    logic       ex_reg_write;
    reg_idx_t   ex_rd;
    word_t      ex_result;
    logic       ex_ecall;

    // write-back, also the forwarding source
    logic       wb_we;
    reg_idx_t   wb_idx;
    word_t      wb_data;

    rv_fetch u_fetch (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start),
        .i_is_ecall(is_ecall),
        .i_redirect(redirect), .i_redirect_pc(redirect_pc),
        .o_pc(o_imem_addr), .o_fetch_valid(fetch_valid)
    );

    rv_decode u_decode (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_inst(i_imem_data), .i_pc(o_imem_addr), .i_fetch_valid(fetch_valid),
        .o_is_ecall(is_ecall),
        .o_valid(dec_valid), .o_pc(dec_pc),
        .o_rd(dec_rd), .o_rs1(dec_rs1), .o_rs2(dec_rs2),
        .o_imm(dec_imm), .o_alu_op(dec_alu_op), .o_use_imm(dec_use_imm),
        .o_reg_write(dec_reg_write), .o_branch(dec_branch),
        .o_br_funct3(dec_br_funct3), .o_jump(dec_jump), .o_ecall(dec_ecall)
    );

    rv_regfile u_regfile (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_we(wb_we), .i_wr_idx(wb_idx), .i_wr_data(wb_data),
        .i_rd_idx1(dec_rs1), .i_rd_idx2(dec_rs2),
        .o_rd_data1(rf_data1), .o_rd_data2(rf_data2)
    );

    rv_execute u_execute (
        .i_valid(dec_valid), .i_pc(dec_pc),
        .i_rs1(dec_rs1), .i_rs2(dec_rs2), .i_rd(dec_rd),
        .i_rs1_data(rf_data1), .i_rs2_data(rf_data2), .i_imm(dec_imm),
        .i_alu_op(dec_alu_op), .i_use_imm(dec_use_imm), .i_reg_write(dec_reg_write),
        .i_branch(dec_branch), .i_br_funct3(dec_br_funct3),
        .i_jump(dec_jump), .i_ecall(dec_ecall),
        .i_fwd_we(wb_we), .i_fwd_idx(wb_idx), .i_fwd_data(wb_data),
        .o_redirect(redirect), .o_redirect_pc(redirect_pc),
        .o_reg_write(ex_reg_write), .o_rd(ex_rd), .o_result(ex_result),
        .o_ecall(ex_ecall)
    );

    rv_result u_result (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_reg_write(ex_reg_write), .i_rd(ex_rd), .i_result(ex_result),
        .i_ecall(ex_ecall),
        .o_wb_we(wb_we), .o_wb_idx(wb_idx), .o_wb_data(wb_data),
        .o_ecall_ready(o_ecall_ready), .o_ecall_data(o_ecall_data)
    );

endmodule

/* tb_rv_ref.svh */
// ------------------------------------------------
// testbench helpers: encoders, LFSR, reference ISA model
// ------------------------------------------------
`ifndef TB_RV_REF_SVH
`define TB_RV_REF_SVH

function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic word_t enc_i(input logic [6:0] opc, input logic [11:0] imm,
                                input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
    return {imm, rd, OPC_LUI};
endfunction

// off is a byte offset, bit 0 dropped
function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs2, input reg_idx_t rs1,
                                input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic word_t enc_j(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// 16-bit fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
endfunction

function automatic word_t ref_alu(input logic [2:0] f3, input logic alt, input word_t a,
                                 input word_t b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'd0, $signed(a) < $signed(b)};
        3'b011:  return {31'd0, a < b};
        3'b100:  return a ^ b;
        3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// runs the program from word 0 to its ecall, returns x10
function automatic word_t ref_run(input word_t prog [256], output int steps);
    word_t      x [32];
    pc_t        pc;
    pc_t        next;
    word_t      w;
    word_t      a;
    word_t      b;
    word_t      r;
    word_t      imm;
    logic [2:0] f3;
    reg_idx_t   rd;
    logic       wr;
    logic       take;
    for (int i = 0; i < 32; i++) x[i] = '0;
    pc = '0;
    steps = 0;
    for (int n = 0; n < 4096; n++) begin
        w = prog[pc];
        steps++;
        if (w == 32'h0000_0073) return x[10];
        f3   = w[14:12];
        rd   = w[11:7];
        a    = x[w[19:15]];
        b    = x[w[24:20]];
        next = pc + 8'd1;
        wr   = 1'b0;
        r    = '0;
        case (w[6:0])
            OPC_OP: begin
                wr = 1'b1;
                r  = ref_alu(f3, w[30], a, b);
            end
            OPC_OP_IMM: begin
                wr  = 1'b1;
                imm = {{20{w[31]}}, w[31:20]};
                r   = ref_alu(f3, w[30] && (f3 == 3'b101), a, imm);
            end
            OPC_LUI: begin
                wr = 1'b1;
                r  = {w[31:12], 12'd0};
            end
            OPC_BRANCH: begin
                imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = $signed(a) < $signed(b);
                    3'b101:  take = $signed(a) >= $signed(b);
                    3'b110:  take = a < b;
                    3'b111:  take = a >= b;
                    default: take = 1'b0;
                endcase
                if (take) next = pc + imm[9:2];
            end
            OPC_JAL: begin
                wr   = 1'b1;
                r    = {22'd0, next, 2'b00};
                imm  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                next = pc + imm[9:2];
            end
            default: begin
                // not an instruction of this core, skipped
            end
        endcase
        if (wr && rd != '0) x[rd] = r;
        pc = next;
    end
    return x[10];
endfunction

`endif

/* tb_rv_core.sv */
// ------------------------------------------------
// testbench for the rv32i core
// random programs checked against a reference model
// ------------------------------------------------
`timescale 1ns/100ps

module tb_rv_core import rv_pkg::*;;

    logic  i_clk;
    logic  i_rst_n;
    logic  i_start;
    pc_t   o_imem_addr;
    word_t i_imem_data;
    logic  o_ecall_ready;
    word_t o_ecall_data;

    word_t       prog [256];
    int          wp;
    logic [15:0] lfsr_state = 16'd94;
    word_t       exp_x10;
    logic        armed = 1'b0;
    int          seen = 0;
    pc_t         held_addr;
    int          cycles = 0;
    int          cycle_limit = 100;

    `include "tb_rv_ref.svh"

    rv_core i_dut (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start),
        .o_imem_addr(o_imem_addr), .i_imem_data(i_imem_data),
        .o_ecall_ready(o_ecall_ready), .o_ecall_data(o_ecall_data)
    );

    // combinational instruction memory
    assign i_imem_data = prog[o_imem_addr];

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    task automatic check_value(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    always @(posedge i_clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Simulation failed");
            $fatal(1, "timeout: the core did not report its ecall in time");
        end
    end

    // result compare sampled away from the active edge
    always @(negedge i_clk) begin
        if (armed && (o_ecall_ready || seen > 0)) begin
            check_value("o_ecall_ready", 32'd1, {31'd0, o_ecall_ready});
            check_value("o_ecall_data", exp_x10, o_ecall_data);
            if (seen == 0) held_addr = o_imem_addr;
            else check_value("o_imem_addr", {24'd0, held_addr}, {24'd0, o_imem_addr});
            seen++;
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // x1..x7 and x10 only
    function automatic reg_idx_t pick_reg();
        logic [31:0] r;
        r = rand_bits(3);
        if (r[2:0] == 3'd7) return 5'd10;
        return {2'b00, r[2:0] + 3'd1};
    endfunction

    function automatic word_t poison_word(input pc_t a);
        return enc_i(OPC_OP_IMM, {4'h5, a}, 5'd10, 3'b000, 5'd10);
    endfunction

    task automatic put(input word_t w);
        prog[wp] = w;
        wp++;
    endtask

    task automatic clear_prog();
        for (int i = 0; i < 256; i++) prog[i] = poison_word(pc_t'(i));
        wp = 0;
    endtask

    task automatic gen_alu_prog(input int len);
        logic [31:0] r;
        logic [31:0] k;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        logic        alt;
        logic        after_x0;
        clear_prog();
        after_x0 = 1'b0;
        for (int i = 0; i < len; i++) begin
            k  = rand_bits(2);
            r  = rand_bits(3);
            // some writes to x0
            rd = (r[2:0] == 3'd0) ? 5'd0 : pick_reg();
            // x0 is read right after a write to it
            rs1 = after_x0 ? 5'd0 : pick_reg();
            r  = rand_bits(20);
            alt = r[19] && (r[2:0] == 3'd0 || r[2:0] == 3'd5);
            case (k[1:0])
                2'd2: begin
                    if (r[2:0] == 3'd1 || r[2:0] == 3'd5)
                        put(enc_i(OPC_OP_IMM, {1'b0, alt, 5'd0, r[8:4]}, rs1, r[2:0], rd));
                    else
                        put(enc_i(OPC_OP_IMM, r[15:4], rs1, r[2:0], rd));
                end
                2'd3: put(enc_u(r[19:0], rd));
                default: put(enc_r({1'b0, alt, 5'd0}, pick_reg(), rs1, r[2:0], rd));
            endcase
            after_x0 = (rd == 5'd0);
        end
        put(32'h0000_0073);
        put(poison_word(pc_t'(wp)));
    endtask

    task automatic gen_branch_prog();
        logic [31:0] r;
        int          loop_pc;
        int          off;
        logic [2:0]  conds [6];
        conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        clear_prog();
        r = rand_bits(20);
        put(enc_u(r[19:0], 5'd2));
        r = rand_bits(2);
        put(enc_i(OPC_OP_IMM, {10'd0, r[1:0]} + 12'd3, 5'd0, 3'b000, 5'd1));
        put(enc_i(OPC_OP_IMM, 12'd0, 5'd0, 3'b000, 5'd10));
        loop_pc = wp;
        // fresh operands each pass
        // x3 never equals x2
        r = rand_bits(24);
        put(enc_i(OPC_OP_IMM, r[11:0], 5'd2, 3'b000, 5'd2));
        put(enc_i(OPC_OP_IMM, r[23:12] | 12'h801, 5'd2, 3'b100, 5'd3));
        for (int c = 0; c < 6; c++) begin
            put(enc_b(13'd8, 5'd3, 5'd2, conds[c]));
            put(poison_word(pc_t'(wp)));
            put(enc_b(13'd8, 5'd2, 5'd3, conds[c]));
            put(poison_word(pc_t'(wp)));
            put(enc_b(13'd8, 5'd2, 5'd2, conds[c]));
            put(poison_word(pc_t'(wp)));
        end
        put(enc_i(OPC_OP_IMM, 12'hfff, 5'd1, 3'b000, 5'd1));
        off = (loop_pc - wp) * 4;
        put(enc_b(off[12:0], 5'd0, 5'd1, 3'b001));
        put(poison_word(pc_t'(wp)));
        put(32'h0000_0073);
        put(poison_word(pc_t'(wp)));
    endtask

    task automatic gen_jal_prog(output int jal_pc);
        logic [31:0] r;
        clear_prog();
        r = rand_bits(15);
        put(enc_i(OPC_OP_IMM, r[11:0], 5'd0, 3'b000, 5'd10));
        for (int i = 0; i < int'(r[14:12]); i++) put(enc_i(OPC_OP_IMM, 12'd0, 5'd0, 3'b000, 5'd0));
        jal_pc = wp;
        put(enc_j(21'd8, 5'd5));
        put(poison_word(pc_t'(wp)));
        put(enc_i(OPC_OP_IMM, 12'd0, 5'd5, 3'b000, 5'd10));
        put(32'h0000_0073);
        put(poison_word(pc_t'(wp)));
    endtask

    task automatic apply_reset();
        @(posedge i_clk);
        i_rst_n <= 1'b0;
        i_start <= 1'b0;
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b1;
    endtask

    // idle outputs after reset and before start
    task automatic check_idle();
        @(negedge i_clk);
        check_value("o_ecall_ready", 32'd0, {31'd0, o_ecall_ready});
        check_value("o_ecall_data", 32'd0, o_ecall_data);
        check_value("o_imem_addr", 32'd0, {24'd0, o_imem_addr});
    endtask

    task automatic run_program();
        int steps;
        exp_x10 = ref_run(prog, steps);
        cycle_limit += 4 * steps + 100;
        apply_reset();
        check_idle();
        @(posedge i_clk);
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        seen  = 0;
        armed = 1'b1;
        // ready and then 20 more cycles of stable outputs
        while (seen < 21) @(posedge i_clk);
        armed = 1'b0;
    endtask

    initial begin
        int    jal_pc;
        int    steps;
        word_t link;
        i_rst_n <= 1'b0;
        i_start <= 1'b0;
        clear_prog();

        apply_reset();
        check_idle();

        for (int t = 0; t < 4; t++) begin
            gen_alu_prog(40);
            run_program();
        end
        for (int t = 0; t < 2; t++) begin
            gen_branch_prog();
            run_program();
        end
        for (int t = 0; t < 2; t++) begin
            gen_jal_prog(jal_pc);
            link = ref_run(prog, steps);
            check_value("reference link", 32'(4 * (jal_pc + 1)), link);
            run_program();
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* rv_core.f */
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_result.sv
rv_core.sv
tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_core -f rv_core.f \
    -Mdir obj_dir -o sim_rv_core
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/sim_rv_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
fi
exit $status
